//--- hw/led_chaser.sv
`timescale 1ns/1ps

module led_chaser #(
  parameter int unsigned TICKS_LED = organ_pkg::DEF_TICKS_LED
) (
  input  logic       CLK_50M,
  input  logic       rst_n,
  output logic [7:0] led
);

  localparam int CNT_W = $clog2(TICKS_LED);

  logic [CNT_W-1:0] cnt;
  logic             step;

  // Step tick
  assign step = (cnt == CNT_W'(TICKS_LED - 1));

  always_ff @(posedge CLK_50M or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (step) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // One lit LED moving left, bit 7 wraps around
  always_ff @(posedge CLK_50M or negedge rst_n) begin
    if (!rst_n) begin
      led <= 8'b0000_0001;
    end else if (step) begin
      led <= {led[6:0], led[7]};
    end
  end

endmodule

//--- hw/organ_pkg.sv
package organ_pkg;

  // ====================
  // Notes
  // ====================

  localparam int NOTE_COUNT = 8;

  typedef logic [2:0] note_idx_t;

  // Full period of each note in CLK_50M cycles, Do up to high Do
  localparam logic [31:0] NOTE_PERIOD [0:NOTE_COUNT-1] = '{
    32'd95602,
    32'd85179,
    32'd75873,
    32'd71633,
    32'd63857,
    32'd56818,
    32'd50659,
    32'd47801
  };

  typedef struct packed {
    note_idx_t note_idx;
    logic      tone_on;
  } switch_t;

  // Active low at the pins, active high once synchronized
  typedef struct packed {
    logic speed_up;
    logic speed_down;
    logic speed_reset;
  } keys_t;

  typedef logic signed [7:0] sample_t;

  // ====================
  // Sample rate setting
  // ====================

  typedef logic [15:0] count_t;

  localparam count_t DEFAULT_SAMPLE_COUNT = 16'd12499;
  localparam int     SPEED_STEP           = 100;
  // Keeps the count above zero
  localparam int     SPEED_LIMIT          = 12400;

  // ====================
  // Seven-segment
  // ====================

  // Active low, bit 0 is segment a
  typedef logic [5:0][6:0] hex_t;

  localparam logic [6:0] SEG_PATTERN [0:15] = '{
    7'h40, 7'h79, 7'h24, 7'h30,
    7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03,
    7'h46, 7'h21, 7'h06, 7'h0E
  };

  // Board tick periods at 50 MHz
  localparam int unsigned DEF_TICKS_LED     = 50_000_000;
  localparam int unsigned DEF_TICKS_REPEAT  = 5_000_000;
  localparam int unsigned DEF_TICKS_DISPLAY = 25_000_000;

endpackage

//--- hw/organ_top.sv
`timescale 1ns/1ps

module organ_top #(
  parameter int unsigned TICKS_LED     = organ_pkg::DEF_TICKS_LED,
  parameter int unsigned TICKS_REPEAT  = organ_pkg::DEF_TICKS_REPEAT,
  parameter int unsigned TICKS_DISPLAY = organ_pkg::DEF_TICKS_DISPLAY
) (
  input  logic               CLK_50M,
  input  logic               rst_n,
  input  organ_pkg::switch_t sw,
  input  organ_pkg::keys_t   key_n,
  output logic               tone,
  output organ_pkg::sample_t sample,
  output logic [7:0]         led,
  output organ_pkg::hex_t    hex
);

  import organ_pkg::*;

  switch_t sel;
  keys_t   keys;
  count_t  sample_count;

  // ====================
  // Input synchronizers
  // ====================

  sync_stage #(
    .payload_t(switch_t)
  ) i_sync_sw (
    .CLK_50M(CLK_50M),
    .rst_n  (rst_n),
    .din    (sw),
    .dout   (sel)
  );

  // Keys are active low at the pins
  sync_stage #(
    .payload_t(keys_t)
  ) i_sync_keys (
    .CLK_50M(CLK_50M),
    .rst_n  (rst_n),
    .din    (keys_t'(~key_n)),
    .dout   (keys)
  );

  // ====================
  // Functional blocks
  // ====================

  tone_gen i_tone_gen (
    .CLK_50M(CLK_50M),
    .rst_n  (rst_n),
    .sel    (sel),
    .tone   (tone),
    .sample (sample)
  );

  led_chaser #(
    .TICKS_LED(TICKS_LED)
  ) i_led_chaser (
    .CLK_50M(CLK_50M),
    .rst_n  (rst_n),
    .led    (led)
  );

  speed_control #(
    .TICKS_REPEAT(TICKS_REPEAT)
  ) i_speed_control (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .keys        (keys),
    .sample_count(sample_count)
  );

  seg7_display #(
    .TICKS_DISPLAY(TICKS_DISPLAY)
  ) i_seg7_display (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .sample_count(sample_count),
    .hex         (hex)
  );

endmodule

//--- hw/seg7_display.sv
`timescale 1ns/1ps

module seg7_display #(
  parameter int unsigned TICKS_DISPLAY = organ_pkg::DEF_TICKS_DISPLAY
) (
  input  logic              CLK_50M,
  input  logic              rst_n,
  input  organ_pkg::count_t sample_count,
  output organ_pkg::hex_t   hex
);

  import organ_pkg::*;

  localparam int CNT_W = $clog2(TICKS_DISPLAY);

  logic [CNT_W-1:0] cnt;
  logic             refresh;
  logic [23:0]      shown;

  // ====================
  // Display refresh
  // ====================

  assign refresh = (cnt == CNT_W'(TICKS_DISPLAY - 1));

  always_ff @(posedge CLK_50M or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (refresh) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Slow latch keeps the digits steady while a key is held
  always_ff @(posedge CLK_50M or negedge rst_n) begin
    if (!rst_n) begin
      shown <= {8'h00, DEFAULT_SAMPLE_COUNT};
    end else if (refresh) begin
      shown <= {8'h00, sample_count};
    end
  end

  // ====================
  // Digit decode
  // ====================

  // Digit 0 is the low nibble
  always_comb begin
    for (int i = 0; i < 6; i++) begin
      hex[i] = SEG_PATTERN[shown[4*i +: 4]];
    end
  end

endmodule

//--- hw/speed_control.sv
`timescale 1ns/1ps

module speed_control #(
  parameter int unsigned TICKS_REPEAT = organ_pkg::DEF_TICKS_REPEAT
) (
  input  logic               CLK_50M,
  input  logic               rst_n,
  input  organ_pkg::keys_t   keys,
  output organ_pkg::count_t  sample_count
);

  import organ_pkg::*;

  localparam int CNT_W = $clog2(TICKS_REPEAT);

  logic [CNT_W-1:0]   cnt;
  logic               repeat_tick;
  logic signed [15:0] offset;
  int                 delta;
  int                 stepped;

  // ====================
  // Repeat tick
  // ====================

  // Limits how fast a held key changes the setting
  assign repeat_tick = (cnt == CNT_W'(TICKS_REPEAT - 1));

  always_ff @(posedge CLK_50M or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (repeat_tick) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // ====================
  // Offset
  // ====================

  // Both keys held cancel out
  always_comb begin
    delta = 0;
    if (keys.speed_up) begin
      delta = delta + SPEED_STEP;
    end
    if (keys.speed_down) begin
      delta = delta - SPEED_STEP;
    end
    stepped = int'(offset) + delta;
    // Saturate in both directions
    if (stepped > SPEED_LIMIT) begin
      stepped = SPEED_LIMIT;
    end else if (stepped < -SPEED_LIMIT) begin
      stepped = -SPEED_LIMIT;
    end
  end

  // Reset key acts at once, no tick needed
  always_ff @(posedge CLK_50M or negedge rst_n) begin
    if (!rst_n) begin
      offset <= '0;
    end else if (keys.speed_reset) begin
      offset <= '0;
    end else if (repeat_tick) begin
      offset <= 16'(stepped);
    end
  end

  // Count is the default plus the signed offset
  always_ff @(posedge CLK_50M or negedge rst_n) begin
    if (!rst_n) begin
      sample_count <= DEFAULT_SAMPLE_COUNT;
    end else begin
      sample_count <= count_t'(int'(DEFAULT_SAMPLE_COUNT) + int'(offset));
    end
  end

endmodule

//--- hw/sync_stage.sv
`timescale 1ns/1ps

module sync_stage #(
  parameter type payload_t = organ_pkg::keys_t
) (
  input  logic     CLK_50M,
  input  logic     rst_n,
  input  payload_t din,
  output payload_t dout
);

  // First stage may go metastable
  payload_t meta;

  always_ff @(posedge CLK_50M or negedge rst_n) begin
    if (!rst_n) begin
      meta <= payload_t'('0);
      dout <= payload_t'('0);
    end else begin
      meta <= din;
      dout <= meta;
    end
  end

endmodule

//--- hw/tone_gen.sv
`timescale 1ns/1ps

module tone_gen (
  input  logic               CLK_50M,
  input  logic               rst_n,
  input  organ_pkg::switch_t sel,
  output logic               tone,
  output organ_pkg::sample_t sample
);

  import organ_pkg::*;

  logic [31:0] half_period;
  logic [31:0] cnt;
  switch_t     sel_q;
  logic        restart;

  // ====================
  // Note lookup
  // ====================

  always_comb begin
    half_period = NOTE_PERIOD[sel.note_idx] >> 1;
  end

  // New note or tone off starts the wave over from low
  assign restart = (sel != sel_q) || !sel.tone_on;

  always_ff @(posedge CLK_50M or negedge rst_n) begin
    if (!rst_n) begin
      sel_q <= '0;
    end else begin
      sel_q <= sel;
    end
  end

  // ====================
  // Square wave
  // ====================

  always_ff @(posedge CLK_50M or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      tone <= 1'b0;
    end else if (restart) begin
      cnt  <= '0;
      tone <= 1'b0;
    end else if (cnt == half_period - 32'd1) begin
      cnt  <= '0;
      tone <= ~tone;
    end else begin
      cnt <= cnt + 32'd1;
    end
  end

  // Signed sample, full scale positive or negative
  // Sign bit is the inverse of the tone
  assign sample = sample_t'({~tone, {7{tone}}});

endmodule

//--- tb.f
hw/organ_pkg.sv
hw/sync_stage.sv
hw/tone_gen.sv
hw/led_chaser.sv
hw/speed_control.sv
hw/seg7_display.sv
hw/organ_top.sv
test/organ_props.sv
test/organ_tb.sv

//--- test/organ_props.sv
`timescale 1ns/1ps

module organ_props (
  input logic               CLK_50M,
  input logic               rst_n,
  input organ_pkg::switch_t sw,
  input logic               tone,
  input organ_pkg::sample_t sample,
  input logic [7:0]         led
);

  // Failures seen so far
  int fail_count = 0;

  led_one_hot: assert property (
    @(posedge CLK_50M) disable iff (!rst_n) $onehot(led)
  ) else begin
    fail_count++;
    $error("led is not one-hot: %b", led);
  end

  // Full scale sample that tracks the wave
  sample_follows_tone: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
      (tone && sample == 8'h7F) || (!tone && sample == 8'h80)
  ) else begin
    fail_count++;
    $error("sample %h does not match tone %b", sample, tone);
  end

  // Two sync stages and the wave register
  tone_quiet_when_off: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
      (!sw.tone_on) [*3] |=> !tone
  ) else begin
    fail_count++;
    $error("tone is high while the tone switch is off");
  end

endmodule

bind organ_top organ_props i_organ_props (
  .CLK_50M(CLK_50M),
  .rst_n  (rst_n),
  .sw     (sw),
  .tone   (tone),
  .sample (sample),
  .led    (led)
);

//--- test/organ_tb.sv
`timescale 1ns/1ps

module organ_tb;

  import organ_pkg::*;

  localparam int TICKS_LED     = 64;
  localparam int TICKS_REPEAT  = 32;
  localparam int TICKS_DISPLAY = 16;

  logic       CLK_50M;
  logic       rst_n;
  switch_t    sw;
  keys_t      key_n;
  logic       tone;
  sample_t    sample;
  logic [7:0] led;
  hex_t       hex;

  // Reference note periods and glyph shapes
  int period_ref [0:7] = '{95602, 85179, 75873, 71633,
                           63857, 56818, 50659, 47801};
  logic [6:0] glyph_ref [0:15] = '{7'h40, 7'h79, 7'h24, 7'h30,
                                   7'h19, 7'h12, 7'h02, 7'h78,
                                   7'h00, 7'h10, 7'h08, 7'h03,
                                   7'h46, 7'h21, 7'h06, 7'h0E};

  organ_top #(
    .TICKS_LED    (TICKS_LED),
    .TICKS_REPEAT (TICKS_REPEAT),
    .TICKS_DISPLAY(TICKS_DISPLAY)
  ) i_organ_top (
    .CLK_50M(CLK_50M),
    .rst_n  (rst_n),
    .sw     (sw),
    .key_n  (key_n),
    .tone   (tone),
    .sample (sample),
    .led    (led),
    .hex    (hex)
  );

  initial begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ====================
  // Helpers
  // ====================

  task automatic fail_stop;
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic expect_int(input string what, input int got, input int want);
    assert (got == want) else begin
      $display("Error at %0t ns: %s expected %0d, got %0d", $time, what, want, got);
      fail_stop();
    end
  endtask

  // Bound property failures end the run at once
  always @(negedge CLK_50M) begin
    if (i_organ_top.i_organ_props.fail_count != 0) begin
      $display("Error at %0t ns: a bound property failed", $time);
      fail_stop();
    end
  end

  // Six digits back to a number, -1 for an unknown glyph
  function automatic int shown_value(input hex_t h);
    int value;
    int digit;
    value = 0;
    for (int i = 5; i >= 0; i--) begin
      digit = -1;
      for (int g = 0; g < 16; g++) begin
        if (h[i] == glyph_ref[g]) begin
          digit = g;
        end
      end
      if (digit < 0) begin
        return -1;
      end
      value = value * 16 + digit;
    end
    return value;
  endfunction

  task automatic wait_display(input int want, input int limit);
    int n;
    n = 0;
    @(negedge CLK_50M);
    while (shown_value(hex) != want) begin
      if (n == limit) begin
        $display("Timeout: the display never showed %0d", want);
        fail_stop();
      end
      n++;
      @(negedge CLK_50M);
    end
  endtask

  task automatic wait_tone(input logic level, input int limit);
    int n;
    n = 0;
    while (tone != level) begin
      if (n == limit) begin
        $display("Timeout: tone never reached level %b", level);
        fail_stop();
      end
      n++;
      @(negedge CLK_50M);
    end
  endtask

  // Cycles that tone stays at its present level
  task automatic level_time(input int limit, output int cycles);
    logic level;
    level = tone;
    cycles = 0;
    while (tone == level) begin
      if (cycles == limit) begin
        $display("Timeout: tone stuck at level %b", level);
        fail_stop();
      end
      cycles++;
      @(negedge CLK_50M);
    end
  endtask

  task automatic led_step(output int gap);
    logic [7:0] start;
    start = led;
    gap = 0;
    while (led == start) begin
      if (gap == 2 * TICKS_LED) begin
        $display("Timeout: the LED pattern stopped moving");
        fail_stop();
      end
      gap++;
      @(negedge CLK_50M);
    end
  endtask

  task automatic tone_silent;
    @(posedge CLK_50M);
    sw.tone_on <= 1'b0;
    repeat (4) @(negedge CLK_50M);
    for (int c = 0; c < 100; c++) begin
      expect_int("tone while off", tone, 0);
      expect_int("sample while off", int'($unsigned(sample)), 'h80);
      @(negedge CLK_50M);
    end
  endtask

  // ====================
  // Directed tests
  // ====================

  task automatic after_reset;
    @(negedge CLK_50M);
    expect_int("led after reset", led, 8'b0000_0001);
    expect_int("tone after reset", tone, 0);
    expect_int("sample after reset", int'($unsigned(sample)), 'h80);
    expect_int("display after reset", shown_value(hex), 12499);
  endtask

  task automatic led_rotation;
    int gap;
    logic [7:0] want;
    want = 8'b0000_0001;
    @(negedge CLK_50M);
    for (int s = 0; s < 11; s++) begin
      led_step(gap);
      want = {want[6:0], want[7]};
      // First step comes part way through the count
      if (s > 0) begin
        expect_int("cycles per LED step", gap, TICKS_LED);
      end
      assert (led == want) else begin
        $display("Error at %0t ns: led expected %b, got %b", $time, want, led);
        fail_stop();
      end
    end
  endtask

  task automatic note_periods;
    bit [7:0] used;
    int note;
    int high_t;
    int low_t;
    used = '0;
    for (int k = 0; k < 3; k++) begin
      note = $urandom % 8;
      while (used[note]) begin
        note = (note + 1) % 8;
      end
      used[note] = 1'b1;
      tone_silent();
      @(posedge CLK_50M);
      sw.note_idx <= note_idx_t'(note);
      sw.tone_on  <= 1'b1;
      @(negedge CLK_50M);
      wait_tone(1'b1, period_ref[note]);
      level_time(period_ref[note], high_t);
      level_time(period_ref[note], low_t);
      expect_int("tone high time", high_t, period_ref[note] / 2);
      expect_int("tone low time", low_t, period_ref[note] / 2);
    end
    tone_silent();
  endtask

  task automatic speed_keys;
    @(posedge CLK_50M);
    key_n.speed_up <= 1'b0;
    wait_display(12499 + 100 * 5, 5 * TICKS_REPEAT + 64);
    @(posedge CLK_50M);
    key_n.speed_up <= 1'b1;
    repeat (4 * TICKS_REPEAT) @(negedge CLK_50M);
    expect_int("count after speed up", shown_value(hex), 12999);
    @(posedge CLK_50M);
    key_n.speed_down <= 1'b0;
    wait_display(12999 - 100 * 8, 8 * TICKS_REPEAT + 64);
    @(posedge CLK_50M);
    key_n.speed_down <= 1'b1;
    repeat (4 * TICKS_REPEAT) @(negedge CLK_50M);
    expect_int("count after speed down", shown_value(hex), 12199);
    @(posedge CLK_50M);
    key_n.speed_reset <= 1'b0;
    wait_display(12499, 4 * TICKS_DISPLAY);
    @(posedge CLK_50M);
    key_n.speed_reset <= 1'b1;
  endtask

  task automatic speed_saturation;
    @(posedge CLK_50M);
    key_n.speed_down <= 1'b0;
    wait_display(99, 130 * TICKS_REPEAT);
    // Keep holding well past the limit
    for (int c = 0; c < 20 * TICKS_REPEAT; c++) begin
      @(negedge CLK_50M);
      expect_int("saturated count", shown_value(hex), 99);
    end
    @(posedge CLK_50M);
    key_n.speed_down  <= 1'b1;
    key_n.speed_reset <= 1'b0;
    wait_display(12499, 4 * TICKS_DISPLAY);
    @(posedge CLK_50M);
    key_n.speed_reset <= 1'b1;
  endtask

  initial begin
    void'($urandom(32'h2d5c));
    rst_n = 1'b0;
    sw    = '0;
    key_n = '1;
    repeat (5) @(posedge CLK_50M);
    rst_n <= 1'b1;
    after_reset();
    led_rotation();
    note_periods();
    speed_keys();
    speed_saturation();
    if (i_organ_top.i_organ_props.fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Bound properties failed %0d times", i_organ_top.i_organ_props.fail_count);
      fail_stop();
    end
  end

endmodule
